// ==== build.f ====
+incdir+hw
+incdir+tb
hw/mandel_pkg.sv
hw/escape_alu.sv
hw/escape_iter.sv
hw/frame_scan.sv
hw/shade_select.sv
hw/mandel_top.sv
tb/mandel_tb.sv

// ==== hw/escape_alu.sv ====
// Escape ALU.
// Computes z' = z^2 + c over three cycles with one shared multiplier,
// and flags escape (|z|^2 >= 4) and overflow of the new value.

`timescale 1ns/1ps
`include "mandel_consts.svh"

module escape_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    alu_start,
    input  mandel_pkg::cplx_t       z,
    input  mandel_pkg::point_t      point,
    output logic                    alu_done,
    output mandel_pkg::alu_result_t result
);
    localparam int W  = `MANDEL_BITWIDTH;
    localparam int PW = 2 * `MANDEL_BITWIDTH;
    localparam int XW = PW + 2;

    mandel_pkg::alu_state_e state;
    mandel_pkg::alu_state_e phase;

    logic signed [W-1:0]  zr_q;
    logic signed [W-1:0]  zi_q;
    logic signed [W-1:0]  cr_q;
    logic signed [W-1:0]  ci_q;
    logic signed [W-1:0]  mul_a;
    logic signed [W-1:0]  mul_b;
    logic signed [PW-1:0] mul_full;
    logic signed [PW-1:0] mul_prod;
    logic signed [PW-1:0] p_rr;
    logic signed [PW-1:0] p_ii;
    logic signed [XW-1:0] mag_sum;
    logic signed [XW-1:0] zr_wide;
    logic signed [XW-1:0] zi_wide;

    // True when v fits in W signed bits.
    function automatic logic fits_w(input logic signed [XW-1:0] v);
        return (v[XW-1:W-1] == '0) || (v[XW-1:W-1] == '1);
    endfunction

    // SQUARE only lasts the start cycle, with operands taken straight from the ports.
    assign phase = (state == mandel_pkg::ALU_IDLE && alu_start) ? mandel_pkg::ALU_SQUARE
                                                                 : state;

    ////////////////////
    // Shared multiplier
    ////////////////////

    always_comb begin
        case (phase)
            mandel_pkg::ALU_SQUARE: begin
                mul_a = z.zr;
                mul_b = z.zr;
            end
            mandel_pkg::ALU_CROSS: begin
                mul_a = zi_q;
                mul_b = zi_q;
            end
            default: begin
                mul_a = zr_q;
                mul_b = zi_q;
            end
        endcase
    end

    assign mul_full = mul_a * mul_b;
    assign mul_prod = mul_full >>> `MANDEL_FRAC;

    // Escape test on the input z, full width.
    assign mag_sum = p_rr + mul_prod;

    // New values before the 10-bit truncation.
    assign zr_wide = p_rr - p_ii + cr_q;
    assign zi_wide = (mul_prod <<< 1) + ci_q;

    ////////////////////
    // Sequencing
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= mandel_pkg::ALU_IDLE;
            alu_done <= 1'b0;
        end else begin
            alu_done <= 1'b0;
            case (phase)
                mandel_pkg::ALU_SQUARE: state <= mandel_pkg::ALU_CROSS;
                mandel_pkg::ALU_CROSS:  state <= mandel_pkg::ALU_SUM;
                mandel_pkg::ALU_SUM: begin
                    state    <= mandel_pkg::ALU_IDLE;
                    alu_done <= 1'b1;
                end
                default: state <= mandel_pkg::ALU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (phase)
            mandel_pkg::ALU_SQUARE: begin
                zr_q <= z.zr;
                zi_q <= z.zi;
                cr_q <= point.cr;
                ci_q <= point.ci;
                p_rr <= mul_prod;
            end
            mandel_pkg::ALU_CROSS: begin
                p_ii           <= mul_prod;
                result.escaped <= (mag_sum >= `MANDEL_ESCAPE);
            end
            mandel_pkg::ALU_SUM: begin
                result.z.zr     <= zr_wide[W-1:0];
                result.z.zi     <= zi_wide[W-1:0];
                result.overflow <= !fits_w(zr_wide) || !fits_w(zi_wide);
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/escape_iter.sv ====
// Escape iteration controller.
// Runs z = z^2 + c for one pixel around the escape ALU and reports
// the iteration count when the point escapes, overflows or hits max_ctr.

`timescale 1ns/1ps
`include "mandel_consts.svh"

module escape_iter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pixel_start,
    input  mandel_pkg::point_t           point,
    input  logic [`MANDEL_CTRWIDTH-1:0]  max_ctr,
    output logic                         pixel_done,
    output logic [`MANDEL_CTRWIDTH-1:0]  count
);
    mandel_pkg::iter_state_e state;
    mandel_pkg::cplx_t       z;
    mandel_pkg::alu_result_t result;

    logic alu_start;
    logic alu_done;
    logic ovf_q;
    logic stop;

    // Termination test for the current iteration.
    assign stop = result.escaped || (count == max_ctr) || ovf_q;

    assign pixel_done = (state == mandel_pkg::ITER_DONE);

    ////////////////////
    // Iteration FSM
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= mandel_pkg::ITER_IDLE;
            alu_start <= 1'b0;
            count     <= '0;
            ovf_q     <= 1'b0;
        end else begin
            alu_start <= 1'b0;
            case (state)
                mandel_pkg::ITER_IDLE: begin
                    if (pixel_start) begin
                        count     <= '0;
                        ovf_q     <= 1'b0;
                        alu_start <= 1'b1;
                        state     <= mandel_pkg::ITER_CALC;
                    end
                end
                mandel_pkg::ITER_CALC: begin
                    if (alu_done) begin
                        if (stop) begin
                            state <= mandel_pkg::ITER_DONE;
                        end else begin
                            count     <= count + 1'b1;
                            ovf_q     <= result.overflow;
                            alu_start <= 1'b1;
                        end
                    end
                end
                default: state <= mandel_pkg::ITER_IDLE;
            endcase
        end
    end

    // Running z value.
    always_ff @(posedge clk) begin
        if (state == mandel_pkg::ITER_IDLE && pixel_start) begin
            z <= '0;
        end else if (state == mandel_pkg::ITER_CALC && alu_done && !stop) begin
            z <= result.z;
        end
    end

    escape_alu alu0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_start (alu_start),
        .z         (z),
        .point     (point),
        .alu_done  (alu_done),
        .result    (result)
    );

endmodule

// ==== hw/frame_scan.sv ====
// Frame scanner.
// Latches the configuration on run and walks the frame in row order,
// issuing one pixel at a time and waiting for each to finish.

`timescale 1ns/1ps
`include "mandel_consts.svh"

module frame_scan #(
    parameter int frame_w = `MANDEL_FRAME_W,
    parameter int frame_h = `MANDEL_FRAME_H
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         run,
    input  mandel_pkg::mandel_cfg_t      cfg,
    input  logic                         pixel_done,
    output logic                         pixel_start,
    output mandel_pkg::point_t           point,
    output logic [`MANDEL_CTRWIDTH-1:0]  max_ctr,
    output mandel_pkg::shade_mode_e      shade_mode,
    output logic                         running,
    output logic                         finished
);
    localparam int W  = `MANDEL_BITWIDTH;
    localparam int XW = (frame_w > 1) ? $clog2(frame_w) : 1;
    localparam int YW = (frame_h > 1) ? $clog2(frame_h) : 1;

    mandel_pkg::frame_state_e state;
    mandel_pkg::mandel_cfg_t  cfg_q;

    logic [XW-1:0] x;
    logic [YW-1:0] y;
    logic [W-1:0]  step_inc;
    logic          row_end;
    logic          last_pixel;

    assign step_inc   = {{(W-`MANDEL_STEPWIDTH){1'b0}}, cfg_q.step} + 1'b1;
    assign row_end    = (x == XW'(frame_w - 1));
    assign last_pixel = row_end && (y == YW'(frame_h - 1));

    assign pixel_start = (state == mandel_pkg::FRAME_ISSUE);
    assign running     = (state != mandel_pkg::FRAME_IDLE);
    assign finished    = (state == mandel_pkg::FRAME_IDLE);
    assign max_ctr     = cfg_q.max_ctr;
    assign shade_mode  = cfg_q.shade_mode;

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mandel_pkg::FRAME_IDLE;
            x     <= '0;
            y     <= '0;
        end else begin
            case (state)
                mandel_pkg::FRAME_IDLE: begin
                    if (run) begin
                        x     <= '0;
                        y     <= '0;
                        state <= mandel_pkg::FRAME_ISSUE;
                    end
                end
                mandel_pkg::FRAME_ISSUE: state <= mandel_pkg::FRAME_WAIT;
                mandel_pkg::FRAME_WAIT: begin
                    if (pixel_done) begin
                        if (last_pixel) begin
                            state <= mandel_pkg::FRAME_IDLE;
                        end else begin
                            state <= mandel_pkg::FRAME_ISSUE;
                            if (row_end) begin
                                x <= '0;
                                y <= y + 1'b1;
                            end else begin
                                x <= x + 1'b1;
                            end
                        end
                    end
                end
                default: state <= mandel_pkg::FRAME_IDLE;
            endcase
        end
    end

    // Configuration latch and coordinate stepping, wrapping at W bits.
    always_ff @(posedge clk) begin
        if (state == mandel_pkg::FRAME_IDLE && run) begin
            cfg_q    <= cfg;
            point.cr <= cfg.cr_offset;
            point.ci <= cfg.ci_offset;
        end else if (state == mandel_pkg::FRAME_WAIT && pixel_done && !last_pixel) begin
            if (row_end) begin
                point.cr <= cfg_q.cr_offset;
                point.ci <= point.ci + step_inc;
            end else begin
                point.cr <= point.cr + step_inc;
            end
        end
    end

endmodule

// ==== hw/mandel_consts.svh ====
// Mandelbrot frame renderer constants.
// Fixed-point format, counter widths and the default frame size.

`ifndef MANDEL_CONSTS_SVH
`define MANDEL_CONSTS_SVH

////////////////////
// Fixed-point format
////////////////////

// Signed value width, 3 integer bits.
`define MANDEL_BITWIDTH 10
// Fraction bits.
`define MANDEL_FRAC 7

// Iteration counter and step field widths.
`define MANDEL_CTRWIDTH 10
`define MANDEL_STEPWIDTH 7

// |z|^2 = 4.0 after the product shift.
`define MANDEL_ESCAPE 512

////////////////////
// Default frame
////////////////////

`define MANDEL_FRAME_W 16
`define MANDEL_FRAME_H 12

`endif

// ==== hw/mandel_pkg.sv ====
// Mandelbrot shared types.
// Configuration, point and ALU structs plus the state and shade enums.

`include "mandel_consts.svh"

package mandel_pkg;

    ////////////////////
    // Enums
    ////////////////////

    // Count window selection for the 4-bit shade.
    typedef enum logic [2:0] {
        WIN0   = 3'd0,
        WIN1   = 3'd1,
        WIN2   = 3'd2,
        WIN3   = 3'd3,
        WIN4   = 3'd4,
        WIN5   = 3'd5,
        WIN6   = 3'd6,
        SPREAD = 3'd7
    } shade_mode_e;

    typedef enum logic [1:0] {FRAME_IDLE, FRAME_ISSUE, FRAME_WAIT} frame_state_e;

    typedef enum logic [1:0] {ITER_IDLE, ITER_CALC, ITER_DONE} iter_state_e;

    typedef enum logic [1:0] {ALU_IDLE, ALU_SQUARE, ALU_CROSS, ALU_SUM} alu_state_e;

    ////////////////////
    // Structs
    ////////////////////

    // Frame configuration, sampled on run.
    typedef struct packed {
        logic [`MANDEL_CTRWIDTH-1:0]         max_ctr;
        shade_mode_e                         shade_mode;
        logic [`MANDEL_STEPWIDTH-1:0]        step;
        logic signed [`MANDEL_BITWIDTH-1:0]  cr_offset;
        logic signed [`MANDEL_BITWIDTH-1:0]  ci_offset;
    } mandel_cfg_t;

    typedef struct packed {
        logic signed [`MANDEL_BITWIDTH-1:0] cr;
        logic signed [`MANDEL_BITWIDTH-1:0] ci;
    } point_t;

    typedef struct packed {
        logic signed [`MANDEL_BITWIDTH-1:0] zr;
        logic signed [`MANDEL_BITWIDTH-1:0] zi;
    } cplx_t;

    typedef struct packed {
        cplx_t z;
        logic  escaped;
        logic  overflow;
    } alu_result_t;

endpackage

// ==== hw/mandel_top.sv ====
// Mandelbrot frame renderer top level.
// Frame scanner, escape iteration and shade selection in a chain;
// one shade strobe per pixel, finished once the frame is done.

`timescale 1ns/1ps
`include "mandel_consts.svh"

module mandel_top #(
    parameter int frame_w = `MANDEL_FRAME_W,
    parameter int frame_h = `MANDEL_FRAME_H
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,
    input  mandel_pkg::mandel_cfg_t cfg,
    output logic                    running,
    output logic                    finished,
    output logic [3:0]              ctr_out,
    output logic                    pixel_strobe
);
    mandel_pkg::point_t      point;
    mandel_pkg::shade_mode_e shade_mode;

    logic                         pixel_start;
    logic                         pixel_done;
    logic [`MANDEL_CTRWIDTH-1:0]  max_ctr;
    logic [`MANDEL_CTRWIDTH-1:0]  count;

    frame_scan #(
        .frame_w (frame_w),
        .frame_h (frame_h)
    ) scan0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .cfg         (cfg),
        .pixel_done  (pixel_done),
        .pixel_start (pixel_start),
        .point       (point),
        .max_ctr     (max_ctr),
        .shade_mode  (shade_mode),
        .running     (running),
        .finished    (finished)
    );

    escape_iter iter0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_start (pixel_start),
        .point       (point),
        .max_ctr     (max_ctr),
        .pixel_done  (pixel_done),
        .count       (count)
    );

    shade_select shade0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel_done   (pixel_done),
        .count        (count),
        .shade_mode   (shade_mode),
        .ctr_out      (ctr_out),
        .pixel_strobe (pixel_strobe)
    );

endmodule

// ==== hw/shade_select.sv ====
// Shade selector.
// Picks a 4-bit window of the iteration count and registers it as a shade.

`timescale 1ns/1ps
`include "mandel_consts.svh"

module shade_select (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pixel_done,
    input  logic [`MANDEL_CTRWIDTH-1:0]  count,
    input  mandel_pkg::shade_mode_e      shade_mode,
    output logic [3:0]                   ctr_out,
    output logic                         pixel_strobe
);
    logic [3:0] window;

    // WINk takes bits k+3 down to k.
    always_comb begin
        case (shade_mode)
            mandel_pkg::WIN0:   window = count[3:0];
            mandel_pkg::WIN1:   window = count[4:1];
            mandel_pkg::WIN2:   window = count[5:2];
            mandel_pkg::WIN3:   window = count[6:3];
            mandel_pkg::WIN4:   window = count[7:4];
            mandel_pkg::WIN5:   window = count[8:5];
            mandel_pkg::WIN6:   window = count[9:6];
            mandel_pkg::SPREAD: window = {count[9], count[6], count[3], count[0]};
            default:            window = count[3:0];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctr_out      <= 4'd0;
            pixel_strobe <= 1'b0;
        end else begin
            pixel_strobe <= pixel_done;
            if (pixel_done) begin
                ctr_out <= window;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the Mandelbrot testbench with Verilator and runs it.
# The run counts as passed only if the pass line shows up in the output.

set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module mandel_tb -o mandel_sim

output=$(./obj_dir/mandel_sim)
echo "$output"

if echo "$output" | grep -qxF '** PASS **'; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1

// ==== tb/mandel_ref.svh ====
// Mandelbrot testbench reference model.
// Escape iteration count, shade window, LFSR stepping and value compare.

`ifndef MANDEL_REF_SVH
`define MANDEL_REF_SVH

// Iteration count of one point under the escape rules.
function automatic int escape_count(input logic signed [`MANDEL_BITWIDTH-1:0] cr,
                                    input logic signed [`MANDEL_BITWIDTH-1:0] ci,
                                    input logic [`MANDEL_CTRWIDTH-1:0] max_ctr);
    logic signed [`MANDEL_BITWIDTH-1:0]     zr;
    logic signed [`MANDEL_BITWIDTH-1:0]     zi;
    logic signed [2*`MANDEL_BITWIDTH-1:0]   full;
    logic signed [2*`MANDEL_BITWIDTH-1:0]   p_rr;
    logic signed [2*`MANDEL_BITWIDTH-1:0]   p_ii;
    logic signed [2*`MANDEL_BITWIDTH-1:0]   p_ri;
    logic signed [2*`MANDEL_BITWIDTH+1:0]   nr;
    logic signed [2*`MANDEL_BITWIDTH+1:0]   ni;
    logic esc;
    logic ovf;
    logic done;
    int   count;
    int   lim;
    lim   = 1 << (`MANDEL_BITWIDTH - 1);
    zr    = '0;
    zi    = '0;
    ovf   = 1'b0;
    done  = 1'b0;
    count = 0;
    while (!done) begin
        full = zr * zr;
        p_rr = full >>> `MANDEL_FRAC;
        full = zi * zi;
        p_ii = full >>> `MANDEL_FRAC;
        full = zr * zi;
        p_ri = full >>> `MANDEL_FRAC;
        esc  = ((p_rr + p_ii) >= `MANDEL_ESCAPE);
        nr   = p_rr - p_ii + cr;
        ni   = 2 * p_ri + ci;
        if (esc || count == int'(max_ctr) || ovf) begin
            done = 1'b1;
        end else begin
            ovf   = !((nr >= -lim) && (nr < lim) && (ni >= -lim) && (ni < lim));
            zr    = nr[`MANDEL_BITWIDTH-1:0];
            zi    = ni[`MANDEL_BITWIDTH-1:0];
            count = count + 1;
        end
    end
    return count;
endfunction

// Window k covers count bits k+3..k; SPREAD takes bits 9, 6, 3, 0.
function automatic logic [3:0] shade_of(input int count, input mandel_pkg::shade_mode_e mode);
    logic [`MANDEL_CTRWIDTH-1:0] c;
    logic [3:0]                  shade;
    int                          k;
    c = count[`MANDEL_CTRWIDTH-1:0];
    k = int'(mode);
    if (mode == mandel_pkg::SPREAD) begin
        shade = {c[9], c[6], c[3], c[0]};
    end else begin
        shade = 4'((c >> k) & 'hF);
    end
    return shade;
endfunction

// Galois LFSR, x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
        $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, want);
        error_count++;
    end
endtask

`endif

// ==== tb/mandel_tb.sv ====
// Mandelbrot frame renderer testbench.
// Runs a table of frame configurations through a 4x3 frame and checks
// every shade, the frame flags and the idle behavior against the model.

`timescale 1ns/1ps
`include "mandel_consts.svh"

module mandel_tb;
    localparam int FRAME_W     = 4;
    localparam int FRAME_H     = 3;
    localparam int PIXELS      = FRAME_W * FRAME_H;
    localparam int NUM_ENTRIES = 8;
    localparam int CLK_PERIOD  = 4;
    localparam int CFG_BITS    = $bits(mandel_pkg::mandel_cfg_t);

    logic                    clk;
    logic                    rst_n;
    logic                    run;
    mandel_pkg::mandel_cfg_t cfg;
    logic                    running;
    logic                    finished;
    logic [3:0]              ctr_out;
    logic                    pixel_strobe;

    int          error_count;
    logic [31:0] lfsr_state;
    logic [3:0]  expected [PIXELS];

    `include "mandel_ref.svh"

    mandel_top #(
        .frame_w (FRAME_W),
        .frame_h (FRAME_H)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .cfg          (cfg),
        .running      (running),
        .finished     (finished),
        .ctr_out      (ctr_out),
        .pixel_strobe (pixel_strobe)
    );

    function automatic mandel_pkg::mandel_cfg_t make_cfg(input int cr, input int ci,
            input int step, input int max_ctr, input mandel_pkg::shade_mode_e mode);
        mandel_pkg::mandel_cfg_t c;
        c.cr_offset  = cr[`MANDEL_BITWIDTH-1:0];
        c.ci_offset  = ci[`MANDEL_BITWIDTH-1:0];
        c.step       = step[`MANDEL_STEPWIDTH-1:0];
        c.max_ctr    = max_ctr[`MANDEL_CTRWIDTH-1:0];
        c.shade_mode = mode;
        return c;
    endfunction

    ////////////////////
    // Frame table
    ////////////////////

    // Columns are cr and ci offsets in Q3.7, step, max_ctr and shade mode.
    function automatic mandel_pkg::mandel_cfg_t table_entry(input int idx);
        case (idx)
            0:       return make_cfg(-256, -192, 63, 15, mandel_pkg::WIN0);
            1:       return make_cfg(-64, -32, 15, 20, mandel_pkg::WIN1);
            2:       return make_cfg(200, -20, 15, 40, mandel_pkg::WIN2);
            3:       return make_cfg(400, 300, 7, 30, mandel_pkg::WIN3);
            4:       return make_cfg(-200, -100, 40, 100, mandel_pkg::WIN4);
            5:       return make_cfg(-48, 0, 8, 300, mandel_pkg::WIN5);
            6:       return make_cfg(-40, -16, 4, 700, mandel_pkg::WIN6);
            default: return make_cfg(-300, -60, 50, 1000, mandel_pkg::SPREAD);
        endcase
    endfunction

    // Expected shades of one frame in row order.
    task automatic expect_frame(input mandel_pkg::mandel_cfg_t c);
        logic signed [`MANDEL_BITWIDTH-1:0] cr;
        logic signed [`MANDEL_BITWIDTH-1:0] ci;
        logic [`MANDEL_BITWIDTH-1:0]        inc;
        int                                 n;
        inc = c.step;
        inc = inc + 1'b1;
        ci  = c.ci_offset;
        n   = 0;
        for (int y = 0; y < FRAME_H; y++) begin
            cr = c.cr_offset;
            for (int x = 0; x < FRAME_W; x++) begin
                expected[n] = shade_of(escape_count(cr, ci, c.max_ctr), c.shade_mode);
                n++;
                cr = cr + inc;
            end
            ci = ci + inc;
        end
    endtask

    // One LFSR step per bit taken.
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog sized from the slowest table entry.
    initial begin
        mandel_pkg::mandel_cfg_t e;
        int                      max_seen;
        longint                  limit;
        max_seen = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = table_entry(i);
            if (int'(e.max_ctr) > max_seen) begin
                max_seen = int'(e.max_ctr);
            end
        end
        limit = longint'(NUM_ENTRIES) * PIXELS * 4 * (max_seen + 2) + 2000;
        #(limit * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the frames never completed", limit);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        mandel_pkg::mandel_cfg_t entry;
        logic [63:0]             rnd;
        int                      strobes;
        int                      cycles;
        int                      frame_limit;
        int                      gap;
        bit                      disturbed;
        error_count = 0;
        lfsr_state  = 32'd92824;
        rst_n       = 1'b0;
        run         = 1'b0;
        cfg         = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // Idle after reset.
        repeat (3) begin
            @(negedge clk);
            check_value("finished", finished, 1);
            check_value("running", running, 0);
            check_value("pixel_strobe", pixel_strobe, 0);
            check_value("ctr_out", ctr_out, 0);
        end

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            entry = table_entry(i);
            expect_frame(entry);
            cfg = entry;
            run = 1'b1;
            @(negedge clk);
            run = 1'b0;
            check_value("running", running, 1);
            strobes     = 0;
            cycles      = 0;
            disturbed   = 1'b0;
            frame_limit = PIXELS * 4 * (int'(entry.max_ctr) + 2) + 20;
            while (!finished && cycles < frame_limit) begin
                @(negedge clk);
                cycles++;
                run = 1'b0;
                if (pixel_strobe) begin
                    if (strobes < PIXELS) begin
                        check_value("ctr_out", ctr_out, expected[strobes]);
                    end
                    strobes++;
                end
                // The frame ends with the cycle of its last strobe.
                check_value("running", running, strobes < PIXELS);
                check_value("finished", finished, strobes == PIXELS);
                // Mid-frame noise with a new cfg and a second run pulse.
                if (strobes == 4 && !disturbed) begin
                    rnd       = take_bits(CFG_BITS);
                    cfg       = rnd[CFG_BITS-1:0];
                    run       = 1'b1;
                    disturbed = 1'b1;
                end
            end
            if (!finished) begin
                $display("Frame %0d did not finish within %0d cycles", i, frame_limit);
                error_count++;
            end
            check_value("strobe_count", strobes, PIXELS);
            check_value("running", running, 0);

            gap = int'(take_bits(3));
            repeat (gap) begin
                @(negedge clk);
                check_value("pixel_strobe", pixel_strobe, 0);
                check_value("finished", finished, 1);
            end
        end

        $display("Checks complete with %0d errors", error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
